// ==== src/icebreaker_io_settings.svh ====
// Fixed iCEBreaker I/O map on a 32-bit bus; RX_SYNC_STAGES must be at least 2
`ifndef ICEBREAKER_IO_SETTINGS_SVH
`define ICEBREAKER_IO_SETTINGS_SVH

// I/O region, address bits 31 down to 27
`define IO_REGION_MSB 31
`define IO_REGION_LSB 27
// Pattern those bits must hold, 0x6000_0000 upward
`define IO_REGION 5'b01100

// One-hot slot bits inside the region
`define LED_SLOT_BIT 2
`define UART_SLOT_BIT 3

// Read word bit that carries the receive level
`define UART_RX_RDBIT 8

// Write data bit for the blue LED source
// Only taken together with byte select 3
`define BLUE_SRC_BIT 31

// Flops between the rx pin and the core clock domain
`define RX_SYNC_STAGES 2

`endif

// ==== src/wb_bus_pkg.sv ====
// Processor-side bus types; plain 32-bit strobe/ack bus, byte select on 8-bit lanes
package wb_bus_pkg;

   // Address width of the core
   localparam int BUS_AW = 32;

   // Data width of the core
   localparam int BUS_DW = 32;

   // One select bit per byte lane
   localparam int BUS_SW = BUS_DW / 8;

   // Full byte address
   // Only the region and slot bits are decoded here
   typedef logic [BUS_AW-1:0] bus_addr_t;

   // Read or write data word
   typedef logic [BUS_DW-1:0] bus_data_t;

   // Byte lane select
   // Bit 3 covers data bits 31 to 24
   typedef logic [BUS_SW-1:0] bus_sel_t;

endpackage

// ==== src/board_pins_pkg.sv ====
// Board-side types for the iCEBreaker; four LEDs, LED3 is the blue one
package board_pins_pkg;

   // Number of user LEDs on the board
   localparam int LED_COUNT = 4;

   // LED vector, bit 0 is LED1
   typedef logic [LED_COUNT-1:0] led_vec_t;

   // Position of each LED in the vector
   localparam int LED1_IDX = 0;
   localparam int LED2_IDX = 1;
   // Blue LED
   localparam int LED3_IDX = 2;
   localparam int LED4_IDX = 3;

   // Who drives the blue LED
   typedef logic led3_src_t;

   // CPU writes set LED3
   localparam led3_src_t LED3_SRC_CPU = 1'b0;
   // LED3 shows inverted rx activity
   localparam led3_src_t LED3_SRC_UART = 1'b1;

endpackage

// ==== src/io_decode.sv ====
// Combinational I/O decode; both slots may hit at once, unmatched accesses get no ack
`include "icebreaker_io_settings.svh"

module io_decode (
   // Bus strobe from the core
   input  logic                  stb,
   // Bus address
   input  wb_bus_pkg::bus_addr_t adr,
   // Peripheral acknowledges
   input  logic                  led_ack,
   input  logic                  uart_ack,
   // Synchronized receive level
   input  logic                  rx_level,
   // Peripheral strobes
   output logic                  led_stb,
   output logic                  uart_stb,
   // Merged acknowledge back to the core
   output logic                  ack,
   // Read word back to the core
   output wb_bus_pkg::bus_data_t dat_r
);

   // Access falls into the I/O region
   logic in_region;

   // Slot hits before the strobe is applied
   logic led_hit;
   logic uart_hit;

   // Region check on the top address bits
   assign in_region = (adr[`IO_REGION_MSB:`IO_REGION_LSB] == `IO_REGION);

   // One-hot slot bits
   // Both set means both peripherals take the access
   assign led_hit  = in_region & adr[`LED_SLOT_BIT];
   assign uart_hit = in_region & adr[`UART_SLOT_BIT];

   // Peripheral strobes
   assign led_stb  = stb & led_hit;
   assign uart_stb = stb & uart_hit;

   // Ack merge
   // No slot hit leaves ack low
   assign ack = led_ack | uart_ack;

   // Read word
   // Only the receive level is readable
   always_comb begin
      dat_r = '0;
      // Gated by the UART ack so a LED read returns zero
      dat_r[`UART_RX_RDBIT] = uart_ack & rx_level;
   end

   // Ack must come from a strobed peripheral
   // Checks the peripheral ack paths, not just the OR above
   always_comb begin
      assert final (stb || !ack)
         else $error("ack high while stb is low");
   end

   // Read word stays clear outside a UART access
   always_comb begin
      assert final (uart_ack || (dat_r == '0))
         else $error("dat_r not zero without uart_ack");
   end

endmodule

// ==== src/bitbang_uart.sv ====
// Bit-banged UART pins; software does all bit timing, tx idles high after reset
`include "icebreaker_io_settings.svh"

module bitbang_uart (
   input  logic CLK_I,
   input  logic arst_n,
   // Strobe from the decoder
   input  logic stb,
   // Write enable, level
   input  logic we,
   // Bit 0 of the write data
   input  logic tx_bit,
   // Receive pin, asynchronous to CLK_I
   input  logic rx,
   // Receive level in the clock domain
   output logic rx_level,
   // Combinational acknowledge
   output logic ack,
   // Transmit pin
   output logic tx
);

   // Receive synchronizer chain
   // Bit 0 is the first stage
   logic [`RX_SYNC_STAGES-1:0] rx_sync;

   // Write to the transmit pin this cycle
   logic tx_wr;

   assign tx_wr = stb & we;

   // Synchronizer, reset to the idle line level
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         rx_sync <= '1;
      end else begin
         rx_sync <= {rx_sync[`RX_SYNC_STAGES-2:0], rx};
      end
   end

   // Last stage is the usable level
   assign rx_level = rx_sync[`RX_SYNC_STAGES-1];

   // Transmit pin register
   // Held between writes, software shapes the frame
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         tx <= 1'b1;
      end else if (tx_wr) begin
         tx <= tx_bit;
      end
   end

   // No wait states
   assign ack = stb;

   // tx only moves on the edge that ends a write strobe
   a_tx_only_on_write : assert property (
      @(posedge CLK_I) disable iff (!arst_n)
      $changed(tx) |-> $past(tx_wr)
   ) else $error("tx changed without a write strobe");

endmodule

// ==== src/led_bank.sv ====
// Four board LEDs; blue LED source only changes with byte select 3 set, UART mode ignores writes
`include "icebreaker_io_settings.svh"

module led_bank (
   input  logic                   CLK_I,
   input  logic                   arst_n,
   // Strobe from the decoder
   input  logic                   stb,
   // Write enable, level
   input  logic                   we,
   // Byte select, lane 3 guards the source bit
   input  wb_bus_pkg::bus_sel_t   sel,
   // Write data
   input  wb_bus_pkg::bus_data_t  dat_w,
   // Synchronized receive level
   input  logic                   rx_level,
   // Combinational acknowledge
   output logic                   ack,
   // LED pins
   output board_pins_pkg::led_vec_t led
);

   // Write to this bank this cycle
   logic wr;

   // LED registers
   logic led1_q;
   logic led2_q;
   logic led3_q;
   logic led4_q;

   // Next value of the blue LED
   logic led3_d;

   // Blue LED source select
   board_pins_pkg::led3_src_t blue_src;

   assign wr = stb & we;

   // Plain LEDs and the source select
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         led1_q   <= 1'b0;
         led2_q   <= 1'b0;
         led4_q   <= 1'b0;
         blue_src <= board_pins_pkg::LED3_SRC_CPU;
      end else if (wr) begin
         led1_q <= dat_w[0];
         led2_q <= dat_w[1];
         led4_q <= dat_w[3];
         // Source bit lives in the top byte lane
         if (sel[3]) begin
            blue_src <= board_pins_pkg::led3_src_t'(dat_w[`BLUE_SRC_BIT]);
         end
      end
   end

   // Blue LED next value
   // UART mode mirrors rx activity, line idles high so LED is off
   always_comb begin
      led3_d = led3_q;
      if (blue_src == board_pins_pkg::LED3_SRC_UART) begin
         led3_d = ~rx_level;
      end else if (wr) begin
         led3_d = dat_w[2];
      end
   end

   // Blue LED register
   // One edge behind rx_level in UART mode
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         led3_q <= 1'b0;
      end else begin
         led3_q <= led3_d;
      end
   end

   // Pin order from the board package
   always_comb begin
      led = '0;
      led[board_pins_pkg::LED1_IDX] = led1_q;
      led[board_pins_pkg::LED2_IDX] = led2_q;
      led[board_pins_pkg::LED3_IDX] = led3_q;
      led[board_pins_pkg::LED4_IDX] = led4_q;
   end

   // No wait states
   assign ack = stb;

   // Write data never reaches LED3 while the UART owns it
   // Source is sampled before a same-cycle switch back to CPU
   a_led3_ignores_write : assert property (
      @(posedge CLK_I) disable iff (!arst_n)
      (wr && (blue_src == board_pins_pkg::LED3_SRC_UART))
         |=> (led[board_pins_pkg::LED3_IDX] == ~$past(rx_level))
   ) else $error("LED3 took write data in UART mode");

endmodule

// ==== src/icebreaker_io.sv ====
// iCEBreaker I/O block top; single-cycle strobe, same-cycle ack, no wait states
module icebreaker_io (
   input  logic                     CLK_I,
   input  logic                     arst_n,
   // Bus side, driven by the core
   input  logic                     stb,
   input  logic                     we,
   input  wb_bus_pkg::bus_addr_t    adr,
   input  wb_bus_pkg::bus_data_t    dat_w,
   input  wb_bus_pkg::bus_sel_t     sel,
   output logic                     ack,
   output wb_bus_pkg::bus_data_t    dat_r,
   // Board side
   input  logic                     rx,
   output logic                     tx,
   output board_pins_pkg::led_vec_t led
);

   // Peripheral strobes from the decoder
   logic led_stb;
   logic uart_stb;

   // Peripheral acknowledges
   logic led_ack;
   logic uart_ack;

   // Synchronized receive level, shared by read path and LED bank
   logic rx_level;

   // Address decode and read mux
   io_decode u_decode (
      .stb      (stb),
      .adr      (adr),
      .led_ack  (led_ack),
      .uart_ack (uart_ack),
      .rx_level (rx_level),
      .led_stb  (led_stb),
      .uart_stb (uart_stb),
      .ack      (ack),
      .dat_r    (dat_r)
   );

   // UART pins, only data bit 0 is used
   bitbang_uart u_uart (
      .CLK_I    (CLK_I),
      .arst_n   (arst_n),
      .stb      (uart_stb),
      .we       (we),
      .tx_bit   (dat_w[0]),
      .rx       (rx),
      .rx_level (rx_level),
      .ack      (uart_ack),
      .tx       (tx)
   );

   // LED registers
   led_bank u_leds (
      .CLK_I    (CLK_I),
      .arst_n   (arst_n),
      .stb      (led_stb),
      .we       (we),
      .sel      (sel),
      .dat_w    (dat_w),
      .rx_level (rx_level),
      .ack      (led_ack),
      .led      (led)
   );

endmodule

// ==== verification/tb_icebreaker_io.sv ====
// Directed testbench for the I/O block at 0x6000_0000; stops at the first mismatch or timeout
`include "icebreaker_io_settings.svh"

module tb_icebreaker_io;

   // Slot addresses in the I/O region
   localparam wb_bus_pkg::bus_addr_t REGION_BASE = {`IO_REGION, 27'h0};
   localparam wb_bus_pkg::bus_addr_t LED_ADDR = REGION_BASE | (32'h1 << `LED_SLOT_BIT);
   localparam wb_bus_pkg::bus_addr_t UART_ADDR = REGION_BASE | (32'h1 << `UART_SLOT_BIT);
   localparam wb_bus_pkg::bus_addr_t BOTH_ADDR = LED_ADDR | UART_ADDR;
   // Both slot bits set, but region bits wrong
   localparam wb_bus_pkg::bus_addr_t OUTSIDE_ADDR = 32'h4000_000C;
   // Cycle limit of every wait loop
   localparam int WAIT_CYCLES = 16;

   logic                     CLK_I;
   logic                     arst_n;
   logic                     stb;
   logic                     we;
   wb_bus_pkg::bus_addr_t    adr;
   wb_bus_pkg::bus_data_t    dat_w;
   wb_bus_pkg::bus_sel_t     sel;
   logic                     ack;
   wb_bus_pkg::bus_data_t    dat_r;
   logic                     rx;
   logic                     tx;
   board_pins_pkg::led_vec_t led;

   // Expected pin state
   logic                     tx_model;
   board_pins_pkg::led_vec_t led_model;
   integer                   seed;

   icebreaker_io dut0 (
      .CLK_I (CLK_I),
      .arst_n(arst_n),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .sel   (sel),
      .ack   (ack),
      .dat_r (dat_r),
      .rx    (rx),
      .tx    (tx),
      .led   (led)
   );

   // 8 unit period
   always #4 CLK_I = ~CLK_I;

   task abort_run;
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_leds(input string name, input board_pins_pkg::led_vec_t exp,
                             input board_pins_pkg::led_vec_t act);
      if (act !== exp) begin
         $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input wb_bus_pkg::bus_data_t exp,
                             input wb_bus_pkg::bus_data_t act);
      if (act !== exp) begin
         $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   // Read word for a given receive level, bit 8 only
   function automatic wb_bus_pkg::bus_data_t rx_word(input logic lvl);
      wb_bus_pkg::bus_data_t w;
      w = '0;
      w[`UART_RX_RDBIT] = lvl;
      return w;
   endfunction

   // One strobe cycle, returns at the edge after it plus 1
   task automatic bus_access(input logic wr, input wb_bus_pkg::bus_addr_t a,
                             input wb_bus_pkg::bus_data_t d, input wb_bus_pkg::bus_sel_t s,
                             output logic ack_seen, output wb_bus_pkg::bus_data_t rd_seen);
      @(posedge CLK_I);
      #1;
      stb = 1'b1;
      we = wr;
      adr = a;
      dat_w = d;
      sel = s;
      // Mid-cycle, ack and dat_r are combinational
      #4;
      ack_seen = ack;
      rd_seen = dat_r;
      @(posedge CLK_I);
      #1;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic bus_write(input wb_bus_pkg::bus_addr_t a, input wb_bus_pkg::bus_data_t d,
                            input wb_bus_pkg::bus_sel_t s, output logic ack_seen,
                            output wb_bus_pkg::bus_data_t rd_seen);
      bus_access(1'b1, a, d, s, ack_seen, rd_seen);
   endtask

   task automatic bus_read(input wb_bus_pkg::bus_addr_t a, output logic ack_seen,
                           output wb_bus_pkg::bus_data_t rd_seen);
      bus_access(1'b0, a, '0, 4'b1111, ack_seen, rd_seen);
   endtask

   // Poll the UART slot until the level shows up
   task automatic wait_rx_word(input logic lvl);
      logic                  a;
      wb_bus_pkg::bus_data_t d;
      int                    n;
      logic                  seen;
      n = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_CYCLES) begin
         bus_read(UART_ADDR, a, d);
         check_bit("ack", 1'b1, a);
         seen = (d[`UART_RX_RDBIT] === lvl);
         n++;
      end
      if (!seen) begin
         $display("Receive level %0b never reached the UART read word", lvl);
         abort_run();
      end
      // All other read bits must stay clear
      check_word("dat_r", rx_word(lvl), d);
   endtask

   // Wait for the blue LED to reach a level
   task automatic wait_led3(input logic exp);
      int   n;
      logic seen;
      n = 0;
      seen = (led[board_pins_pkg::LED3_IDX] === exp);
      while (!seen && n < WAIT_CYCLES) begin
         @(posedge CLK_I);
         #1;
         seen = (led[board_pins_pkg::LED3_IDX] === exp);
         n++;
      end
      if (!seen) begin
         $display("Blue LED never reached %0b while following the receive pin", exp);
         abort_run();
      end
   endtask

   task automatic reset_state;
      check_bit("tx", 1'b1, tx);
      check_leds("led", 4'b0000, led);
      check_bit("ack", 1'b0, ack);
      check_word("dat_r", '0, dat_r);
   endtask

   task automatic led_writes;
      logic                  a;
      wb_bus_pkg::bus_data_t d;
      wb_bus_pkg::bus_data_t rd;
      for (int i = 0; i < 8; i++) begin
         d = $random(seed);
         // Lane 3 off, blue source stays with the CPU
         bus_write(LED_ADDR, d, 4'b0001, a, rd);
         check_bit("ack", 1'b1, a);
         check_word("dat_r", '0, rd);
         led_model = d[3:0];
         check_leds("led", led_model, led);
         check_bit("tx", tx_model, tx);
      end
   endtask

   task automatic tx_pin;
      logic                  a;
      wb_bus_pkg::bus_data_t d;
      wb_bus_pkg::bus_data_t rd;
      for (int i = 0; i < 2; i++) begin
         d = $random(seed);
         d[0] = (i == 0) ? 1'b0 : 1'b1;
         bus_write(UART_ADDR, d, 4'b1111, a, rd);
         check_bit("ack", 1'b1, a);
         // rx idles high since reset
         check_word("dat_r", rx_word(1'b1), rd);
         tx_model = d[0];
         check_bit("tx", tx_model, tx);
         check_leds("led", led_model, led);
      end
      // Wrong region, nothing may move
      d = $random(seed);
      d[3:0] = ~led_model;
      d[0] = ~tx_model;
      bus_write(OUTSIDE_ADDR, d, 4'b1111, a, rd);
      check_bit("ack", 1'b0, a);
      check_word("dat_r", '0, rd);
      check_bit("tx", tx_model, tx);
      check_leds("led", led_model, led);
   endtask

   task automatic rx_path;
      logic                  a;
      wb_bus_pkg::bus_data_t rd;
      rx = 1'b0;
      wait_rx_word(1'b0);
      rx = 1'b1;
      wait_rx_word(1'b1);
      // LED slot alone never shows the receive bit
      bus_read(LED_ADDR, a, rd);
      check_bit("ack", 1'b1, a);
      check_word("dat_r", '0, rd);
   endtask

   task automatic blue_source;
      logic                  a;
      wb_bus_pkg::bus_data_t d;
      wb_bus_pkg::bus_data_t rd;
      // Source bit without lane 3 is ignored
      d = $random(seed);
      d[`BLUE_SRC_BIT] = 1'b1;
      d[3:0] = 4'b0100;
      bus_write(LED_ADDR, d, 4'b0111, a, rd);
      led_model = 4'b0100;
      check_leds("led", led_model, led);
      @(posedge CLK_I);
      #1;
      // Still set, so rx does not own LED3
      check_leds("led", led_model, led);
      d[3:0] = 4'b0000;
      bus_write(LED_ADDR, d, 4'b0111, a, rd);
      led_model = 4'b0000;
      check_leds("led", led_model, led);
      // Hand LED3 to the receive pin
      d = $random(seed);
      d[`BLUE_SRC_BIT] = 1'b1;
      d[3:0] = 4'b1111;
      bus_write(LED_ADDR, d, 4'b1000, a, rd);
      wait_led3(1'b0);
      check_leds("led", 4'b1011, led);
      rx = 1'b0;
      wait_led3(1'b1);
      check_leds("led", 4'b1111, led);
      rx = 1'b1;
      wait_led3(1'b0);
      check_leds("led", 4'b1011, led);
      // Writes keep reaching the other three
      d = $random(seed);
      d[2] = 1'b1;
      bus_write(LED_ADDR, d, 4'b0001, a, rd);
      led_model = {d[3], 1'b0, d[1], d[0]};
      check_leds("led", led_model, led);
      @(posedge CLK_I);
      #1;
      check_leds("led", led_model, led);
      // Source clear with lane 3, this edge is still UART mode
      d = $random(seed);
      d[`BLUE_SRC_BIT] = 1'b0;
      d[2] = 1'b1;
      bus_write(LED_ADDR, d, 4'b1000, a, rd);
      led_model = {d[3], 1'b0, d[1], d[0]};
      check_leds("led", led_model, led);
      // CPU owns LED3 again
      d = $random(seed);
      d[2] = 1'b1;
      bus_write(LED_ADDR, d, 4'b0001, a, rd);
      led_model = d[3:0];
      check_leds("led", led_model, led);
   endtask

   task automatic dual_slot;
      logic                  a;
      wb_bus_pkg::bus_data_t d;
      wb_bus_pkg::bus_data_t rd;
      d = $random(seed);
      d[0] = ~tx_model;
      bus_write(BOTH_ADDR, d, 4'b0001, a, rd);
      check_bit("ack", 1'b1, a);
      // UART slot hit, receive bit shows
      check_word("dat_r", rx_word(1'b1), rd);
      tx_model = d[0];
      led_model = d[3:0];
      check_bit("tx", tx_model, tx);
      check_leds("led", led_model, led);
      // Strobe gone, ack must be gone
      #2;
      check_bit("ack", 1'b0, ack);
   endtask

   // Hard limit on the whole run
   initial begin
      #50000;
      $display("Simulation ran past its time limit");
      abort_run();
   end

   initial begin
      CLK_I = 1'b0;
      arst_n = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      sel = '0;
      rx = 1'b1;
      seed = 32'h1feb;
      tx_model = 1'b1;
      led_model = '0;
      repeat (10) @(posedge CLK_I);
      #1;
      arst_n = 1'b1;
      reset_state();
      led_writes();
      tx_pin();
      rx_path();
      blue_source();
      dual_slot();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== icebreaker_io.f ====
+incdir+src
src/wb_bus_pkg.sv
src/board_pins_pkg.sv
src/io_decode.sv
src/bitbang_uart.sv
src/led_bank.sv
src/icebreaker_io.sv
verification/tb_icebreaker_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the I/O block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f icebreaker_io.f \
   --top-module tb_icebreaker_io -o sim_tb

# The simulation exits with an error status on a fatal stop
# Its output is kept and searched instead
out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
   exit 0
fi
exit 1
